// ==== files.f ====
tlk_pkg.sv
tlk_word_if.sv
tlk_link_ctrl.sv
tlk_pattern_gen.sv
tlk_tx_framer.sv
tlk_rx_align.sv
tlk_rx_checker.sv
tlk_link_top.sv
tlk_link_props.sv
tb_tlk_link.sv

// ==== tb_tlk_link.sv ====
module tb_tlk_link;
  import tlk_pkg::*;

  localparam int FRAME_LEN      = 16;
  localparam int POWERUP_CYCLES = 64;
  localparam int CLK_PERIOD     = 10;
  localparam int RESET_CYCLES   = 8;
  // frames over all runs: data 4+4, lfsr 4, errors 6, stop 3+2, serdes 3+3
  localparam int TOTAL_FRAMES   = 29;
  localparam int WATCHDOG_TIME  = TOTAL_FRAMES * (FRAME_LEN + 1) * CLK_PERIOD
                                  + (RESET_CYCLES + POWERUP_CYCLES + 400) * CLK_PERIOD;

  logic        sys_clk_50;
  logic        sys_rstn;
  logic        i_start;
  logic [2:0]  i_mode;
  logic        i_stop_req;
  logic        o_stop_ack;
  logic [15:0] o_txd;
  logic        o_tkmsb;
  logic        o_tklsb;
  logic        o_loopen;
  logic        o_prbsen;
  logic        o_enable;
  logic        o_lckrefn;
  logic        o_testen;
  logic [15:0] i_rxd;
  logic        i_rkmsb;
  logic        i_rklsb;
  logic        o_rx_locked;
  logic [15:0] o_frame_cnt;
  logic [15:0] o_err_cnt;

  logic [15:0] corrupt_mask;
  logic        inject_en;
  int          n_injected;
  logic [31:0] lfsr_state;
  logic [2:0]  exp_mode;     // mode the tx monitor checks against
  int          tx_idx;       // data words since the last comma
  int          tx_frames;
  logic        ack_prev;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          assert_fails;

  tlk_link_top #(
    .FRAME_LEN      (FRAME_LEN),
    .POWERUP_CYCLES (POWERUP_CYCLES)
  ) u_tlk_link_top (
    .sys_clk_50  (sys_clk_50),
    .sys_rstn    (sys_rstn),
    .i_start     (i_start),
    .i_mode      (i_mode),
    .i_stop_req  (i_stop_req),
    .o_stop_ack  (o_stop_ack),
    .o_txd       (o_txd),
    .o_tkmsb     (o_tkmsb),
    .o_tklsb     (o_tklsb),
    .o_loopen    (o_loopen),
    .o_prbsen    (o_prbsen),
    .o_enable    (o_enable),
    .o_lckrefn   (o_lckrefn),
    .o_testen    (o_testen),
    .i_rxd       (i_rxd),
    .i_rkmsb     (i_rkmsb),
    .i_rklsb     (i_rklsb),
    .o_rx_locked (o_rx_locked),
    .o_frame_cnt (o_frame_cnt),
    .o_err_cnt   (o_err_cnt)
  );

  // external loopback, data bits only can be corrupted
  assign i_rxd   = o_txd ^ corrupt_mask;
  assign i_rkmsb = o_tkmsb;
  assign i_rklsb = o_tklsb;

  always #(CLK_PERIOD / 2) sys_clk_50 = ~sys_clk_50;

  function automatic logic [31:0] galois_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[14:0], lfsr_state[0]};
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  function automatic logic has_data(logic [2:0] mode);
    case (mode)
      MODE_COUNT, MODE_LFSR, MODE_ALT, MODE_LOOP: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // expected data word from mode and index in the frame
  function automatic logic [15:0] expected_word(logic [2:0] mode, int idx);
    logic [15:0] r;
    r = 16'h0000;
    case (mode)
      MODE_COUNT, MODE_LOOP: r = 16'(idx);
      MODE_LFSR: begin
        r = LFSR_SEED;
        for (int k = 0; k < idx; k++) begin
          r = {r[0] ^ r[2] ^ r[3] ^ r[5], r[15:1]}; // taps 16 14 13 11
        end
      end
      MODE_ALT: r = (idx % 2 == 1) ? 16'h5555 : 16'hAAAA;
      default: r = 16'h0000;
    endcase
    return r;
  endfunction

  task automatic value_mismatch(input string name, input logic [15:0] exp, input logic [15:0] got);
    $display("[FAIL] %s: expected %h, got %h", name, exp, got);
    err_count++;
  endtask

  task automatic plain_error(input string msg);
    $display("error: %s", msg);
    err_count++;
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run++;
    if (err_count != err0) begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - err0);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // random corruption of data words on the way back
  always @(negedge sys_clk_50) begin
    logic [15:0] pick;
    if (inject_en && o_tklsb === 1'b0 && o_tkmsb === 1'b0) begin
      take_bits(2, pick);
      if (pick[1:0] == 2'b00) begin
        take_bits(16, pick);
        if (pick == 16'h0000) pick = 16'h0001;
        corrupt_mask = pick;
        n_injected++;
      end else begin
        corrupt_mask = 16'h0000;
      end
    end else begin
      corrupt_mask = 16'h0000;
    end
  end

  // tx monitor and compare
  always @(negedge sys_clk_50) begin
    logic is_comma;
    logic is_data;
    is_comma = (o_txd === COMMA_WORD) && (o_tklsb === 1'b1) && (o_tkmsb === 1'b0);
    is_data  = (o_tklsb === 1'b0) && (o_tkmsb === 1'b0);
    if (!sys_rstn) begin
      tx_idx   = FRAME_LEN;
      ack_prev = 1'b0;
    end else begin
      if (is_comma) begin
        if (tx_idx != 0 && tx_idx != FRAME_LEN) begin
          plain_error($sformatf("frame on o_txd ended after %0d data words", tx_idx));
        end
        tx_idx = 0;
      end else if (is_data) begin
        if (!has_data(exp_mode)) begin
          plain_error($sformatf("data word on o_txd in mode %0d", exp_mode));
        end else if (tx_idx >= FRAME_LEN) begin
          plain_error("data word on o_txd without a leading comma");
        end else begin
          if (o_txd !== expected_word(exp_mode, tx_idx)) begin
            value_mismatch($sformatf("o_txd word %0d", tx_idx),
                           expected_word(exp_mode, tx_idx), o_txd);
          end
          tx_idx++;
          if (tx_idx == FRAME_LEN) tx_frames++;
        end
      end else begin
        plain_error("o_txd carries neither a comma nor a data word");
      end
      if (o_stop_ack === 1'b1 && !ack_prev && tx_idx != 0 && tx_idx != FRAME_LEN) begin
        plain_error("stop acknowledged in the middle of a frame");
      end
      if (ack_prev && is_data) begin
        plain_error("data word sent after the stop acknowledge");
      end
      ack_prev = (o_stop_ack === 1'b1);
    end
  end

  // one run from start pulse to completed stop handshake
  task automatic run_frames(input logic [2:0] mode, input int nframes, input int stop_delay);
    int f0;
    int e0;
    int t0;
    int inj0;
    int exp_frames;
    f0   = o_frame_cnt;
    e0   = o_err_cnt;
    t0   = tx_frames;
    inj0 = n_injected;
    exp_frames = has_data(mode) ? nframes : 0;
    exp_mode   = mode;
    i_mode     = mode;
    i_start    = 1'b1;
    @(negedge sys_clk_50);
    i_start = 1'b0;
    if (o_loopen !== (mode == MODE_LOOP)) value_mismatch("o_loopen", mode == MODE_LOOP, o_loopen);
    if (o_prbsen !== (mode == MODE_PRBS)) value_mismatch("o_prbsen", mode == MODE_PRBS, o_prbsen);
    if (has_data(mode)) begin
      wait (tx_frames >= t0 + nframes - 1); // stop lands in the last frame
    end else begin
      repeat (nframes * (FRAME_LEN + 1)) @(negedge sys_clk_50);
    end
    repeat (stop_delay) @(negedge sys_clk_50);
    i_stop_req = 1'b1;
    wait (o_stop_ack === 1'b1);
    repeat (6) begin
      @(negedge sys_clk_50);
      if (o_stop_ack !== 1'b1) value_mismatch("o_stop_ack", 1'b1, o_stop_ack);
    end
    if (o_loopen !== 1'b0 || o_prbsen !== 1'b0) begin
      plain_error("serdes mode pins still set after the stop acknowledge");
    end
    i_stop_req = 1'b0;
    @(negedge sys_clk_50);
    if (o_stop_ack !== 1'b0) value_mismatch("o_stop_ack", 1'b0, o_stop_ack);
    repeat (2) @(negedge sys_clk_50);
    if (tx_frames - t0 != exp_frames) begin
      plain_error($sformatf("%0d frames on o_txd, %0d expected", tx_frames - t0, exp_frames));
    end
    if (o_frame_cnt !== 16'(f0 + exp_frames)) begin
      value_mismatch("o_frame_cnt", 16'(f0 + exp_frames), o_frame_cnt);
    end
    if (o_err_cnt !== 16'(e0 + n_injected - inj0)) begin
      value_mismatch("o_err_cnt", 16'(e0 + n_injected - inj0), o_err_cnt);
    end
    if (o_rx_locked !== 1'b1) value_mismatch("o_rx_locked", 1'b1, o_rx_locked);
  endtask

  task automatic test_powerup();
    int   err0;
    logic exp_up;
    err0 = err_count;
    for (int n = 0; n < POWERUP_CYCLES + 8; n++) begin
      i_start = (n == 20); // early start, must be ignored
      i_mode  = MODE_COUNT;
      @(negedge sys_clk_50);
      exp_up = (n + 1 >= POWERUP_CYCLES);
      if (o_enable !== exp_up) value_mismatch("o_enable", exp_up, o_enable);
      if (o_lckrefn !== exp_up) value_mismatch("o_lckrefn", exp_up, o_lckrefn);
      if (o_loopen !== 1'b0 || o_prbsen !== 1'b0 || o_testen !== 1'b0) begin
        plain_error("serdes control pin high before any start");
      end
      if (o_stop_ack !== 1'b0) value_mismatch("o_stop_ack", 1'b0, o_stop_ack);
      if (o_txd !== COMMA_WORD) value_mismatch("o_txd", COMMA_WORD, o_txd);
      if (o_tklsb !== 1'b1) value_mismatch("o_tklsb", 1'b1, o_tklsb);
    end
    i_mode = MODE_IDLE;
    if (o_rx_locked !== 1'b1) plain_error("receive side did not lock to the idle commas");
    finish_test("reset and power-up", err0);
  endtask

  task automatic test_error_injection();
    int err0;
    int inj0;
    err0 = err_count;
    inj0 = n_injected;
    inject_en = 1'b1;
    run_frames(MODE_COUNT, 6, 0);
    inject_en = 1'b0;
    if (n_injected == inj0) plain_error("no data word was corrupted during the run");
    finish_test($sformatf("error injection, %0d words", n_injected - inj0), err0);
  endtask

  initial begin
    int err0;
    sys_clk_50   = 1'b0;
    sys_rstn     = 1'b0;
    i_start      = 1'b0;
    i_mode       = MODE_IDLE;
    i_stop_req   = 1'b0;
    corrupt_mask = 16'h0000;
    inject_en    = 1'b0;
    n_injected   = 0;
    lfsr_state   = 32'h6e45_2e4a;
    exp_mode     = MODE_IDLE;
    tx_idx       = FRAME_LEN;
    tx_frames    = 0;
    ack_prev     = 1'b0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(negedge sys_clk_50);
    sys_rstn = 1'b1;

    test_powerup();

    err0 = err_count;
    run_frames(MODE_COUNT, 4, 0);
    run_frames(MODE_ALT, 4, 0);
    finish_test("counter and alternating modes", err0);

    err0 = err_count;
    run_frames(MODE_LFSR, 4, 0);
    finish_test("lfsr mode", err0);

    test_error_injection();

    err0 = err_count;
    run_frames(MODE_COUNT, 3, 9); // stop raised mid-frame
    run_frames(MODE_COUNT, 2, 0);
    finish_test("stop handshake", err0);

    err0 = err_count;
    run_frames(MODE_LOOP, 3, 0);
    run_frames(MODE_PRBS, 3, 0);
    finish_test("serdes modes", err0);

    assert_fails = u_tlk_link_top.u_ctrl.u_props.fail_count;
    if (assert_fails != 0) plain_error($sformatf("%0d assertion failures", assert_fails));
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: tests did not finish within %0d time units", WATCHDOG_TIME);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== tlk_link_props.sv ====
module tlk_link_props (
  input logic sys_clk_50,
  input logic sys_rstn,
  input logic i_stop_req,
  input logic o_stop_ack,
  input logic o_loopen,
  input logic o_prbsen
);

  int ack_rise_errs = 0;
  int ack_hold_errs = 0;
  int ack_fall_errs = 0;
  int pin_errs      = 0;
  int fail_count;

  assign fail_count = ack_rise_errs + ack_hold_errs + ack_fall_errs + pin_errs;

  // ack only answers a pending request
  ap_ack_needs_req: assert property (@(posedge sys_clk_50) disable iff (!sys_rstn)
    $rose(o_stop_ack) |-> $past(i_stop_req))
    else begin
      $error("stop ack rose without a stop request");
      ack_rise_errs++;
    end

  ap_ack_hold: assert property (@(posedge sys_clk_50) disable iff (!sys_rstn)
    o_stop_ack && i_stop_req |=> o_stop_ack)
    else begin
      $error("stop ack dropped while the request was still high");
      ack_hold_errs++;
    end

  ap_ack_release: assert property (@(posedge sys_clk_50) disable iff (!sys_rstn)
    $fell(i_stop_req) |=> !o_stop_ack)
    else begin
      $error("stop ack still high one cycle after the request fell");
      ack_fall_errs++;
    end

  ap_mode_pins: assert property (@(posedge sys_clk_50) disable iff (!sys_rstn)
    !(o_loopen && o_prbsen))
    else begin
      $error("loopen and prbsen high together");
      pin_errs++;
    end

endmodule

bind tlk_link_ctrl tlk_link_props u_props (
  .sys_clk_50 (sys_clk_50),
  .sys_rstn   (sys_rstn),
  .i_stop_req (i_stop_req),
  .o_stop_ack (o_stop_ack),
  .o_loopen   (o_loopen),
  .o_prbsen   (o_prbsen)
);

// ==== tlk_link_top.sv ====
module tlk_link_top #(
  parameter int FRAME_LEN      = 16,
  parameter int POWERUP_CYCLES = 64
) (
  input  logic        sys_clk_50,
  input  logic        sys_rstn,
  // test control
  input  logic        i_start,
  input  logic [2:0]  i_mode,
  input  logic        i_stop_req,
  output logic        o_stop_ack,
  // tlk2711 transmit side
  output logic [15:0] o_txd,
  output logic        o_tkmsb,
  output logic        o_tklsb,
  output logic        o_loopen,
  output logic        o_prbsen,
  output logic        o_enable,
  output logic        o_lckrefn,
  output logic        o_testen,
  // tlk2711 receive side
  input  logic [15:0] i_rxd,
  input  logic        i_rkmsb,
  input  logic        i_rklsb,
  // status
  output logic        o_rx_locked,
  output logic [15:0] o_frame_cnt,
  output logic [15:0] o_err_cnt
);
  import tlk_pkg::*;

  tlk_mode_e run_mode;  // latched at start, shared by tx and rx
  logic      run;
  logic      frame_end;

  tlk_word_if gen_if ();
  tlk_word_if rx_if ();

  tlk_link_ctrl #(
    .POWERUP_CYCLES (POWERUP_CYCLES)
  ) u_ctrl (
    .sys_clk_50  (sys_clk_50),
    .sys_rstn    (sys_rstn),
    .i_start     (i_start),
    .i_mode      (tlk_mode_e'(i_mode)),
    .i_stop_req  (i_stop_req),
    .i_frame_end (frame_end),
    .o_run       (run),
    .o_mode      (run_mode),
    .o_stop_ack  (o_stop_ack),
    .o_enable    (o_enable),
    .o_lckrefn   (o_lckrefn),
    .o_loopen    (o_loopen),
    .o_prbsen    (o_prbsen),
    .o_testen    (o_testen)
  );

  tlk_pattern_gen #(
    .FRAME_LEN (FRAME_LEN)
  ) u_gen (
    .sys_clk_50 (sys_clk_50),
    .sys_rstn   (sys_rstn),
    .i_run      (run),
    .i_mode     (run_mode),
    .o_word     (gen_if.src)
  );

  tlk_tx_framer #(
    .FRAME_LEN (FRAME_LEN)
  ) u_framer (
    .sys_clk_50  (sys_clk_50),
    .sys_rstn    (sys_rstn),
    .i_word      (gen_if.snk),
    .o_frame_end (frame_end),
    .o_txd       (o_txd),
    .o_tkmsb     (o_tkmsb),
    .o_tklsb     (o_tklsb)
  );

  // receive path runs on the same clock in the loopback build
  tlk_rx_align #(
    .FRAME_LEN (FRAME_LEN)
  ) u_align (
    .sys_clk_50 (sys_clk_50),
    .sys_rstn   (sys_rstn),
    .i_rxd      (i_rxd),
    .i_rkmsb    (i_rkmsb),
    .i_rklsb    (i_rklsb),
    .o_word     (rx_if.src),
    .o_locked   (o_rx_locked)
  );

  tlk_rx_checker #(
    .FRAME_LEN (FRAME_LEN)
  ) u_checker (
    .sys_clk_50  (sys_clk_50),
    .sys_rstn    (sys_rstn),
    .i_mode      (run_mode),
    .i_word      (rx_if.snk),
    .o_frame_cnt (o_frame_cnt),
    .o_err_cnt   (o_err_cnt)
  );

endmodule

// ==== tlk_rx_checker.sv ====
module tlk_rx_checker #(
  parameter int FRAME_LEN = 16
) (
  input  logic               sys_clk_50,
  input  logic               sys_rstn,
  input  tlk_pkg::tlk_mode_e i_mode,
  tlk_word_if.snk            i_word,
  output logic [15:0]        o_frame_cnt,
  output logic [15:0]        o_err_cnt
);
  import tlk_pkg::*;

  logic check_en;
  logic mismatch;
  logic last_word;
  logic in_frame;  // sof of the current frame was seen

  assign check_en  = i_word.valid && mode_has_data(i_mode);
  assign last_word = (i_word.idx == 16'(FRAME_LEN - 1));

  // a stray K flag on a data word counts as an error too
  assign mismatch = (i_word.data != pattern_word(i_mode, i_word.idx))
                    || i_word.kmsb || i_word.klsb;

  always_ff @(posedge sys_clk_50) begin
    if (!sys_rstn) begin
      o_frame_cnt <= '0;
      o_err_cnt   <= '0;
      in_frame    <= 1'b0;
    end else if (check_en) begin
      if (mismatch && o_err_cnt != '1) begin
        o_err_cnt <= o_err_cnt + 16'd1;
      end
      if (last_word) begin
        in_frame <= 1'b0;
        // only frames seen from their first word
        if ((in_frame || i_word.sof) && o_frame_cnt != '1) begin
          o_frame_cnt <= o_frame_cnt + 16'd1;
        end
      end else if (i_word.sof) begin
        in_frame <= 1'b1;
      end
    end
  end

endmodule

// ==== tlk_rx_align.sv ====
module tlk_rx_align #(
  parameter int FRAME_LEN = 16
) (
  input  logic        sys_clk_50,
  input  logic        sys_rstn,
  input  logic [15:0] i_rxd,
  input  logic        i_rkmsb,
  input  logic        i_rklsb,
  tlk_word_if.src     o_word,
  output logic        o_locked
);
  import tlk_pkg::*;

  logic [15:0] rxd_q;
  logic        rkmsb_q;
  logic        rklsb_q;
  logic [15:0] word_cnt; // data words since the last comma
  logic        is_comma;
  logic        data_ok;

  always_ff @(posedge sys_clk_50) begin
    rxd_q <= i_rxd;
  end

  always_ff @(posedge sys_clk_50) begin
    if (!sys_rstn) begin
      rkmsb_q <= 1'b0;
      rklsb_q <= 1'b0;
    end else begin
      rkmsb_q <= i_rkmsb;
      rklsb_q <= i_rklsb;
    end
  end

  assign is_comma = (rxd_q == COMMA_WORD) && rklsb_q && !rkmsb_q;
  assign data_ok  = o_locked && !is_comma && (word_cnt < 16'(FRAME_LEN));

  assign o_word.data  = rxd_q;
  assign o_word.kmsb  = rkmsb_q;
  assign o_word.klsb  = rklsb_q;
  assign o_word.valid = data_ok;
  assign o_word.sof   = data_ok && (word_cnt == '0);
  assign o_word.idx   = word_cnt;

  always_ff @(posedge sys_clk_50) begin
    if (!sys_rstn) begin
      o_locked <= 1'b0;
      word_cnt <= '0;
    end else if (is_comma) begin
      o_locked <= 1'b1;
      word_cnt <= '0;
    end else if (data_ok) begin
      word_cnt <= word_cnt + 16'd1;
    end else if (o_locked && word_cnt == 16'(FRAME_LEN)) begin
      o_locked <= 1'b0; // comma missing after a full frame
    end
  end

endmodule

// ==== tlk_tx_framer.sv ====
module tlk_tx_framer #(
  parameter int FRAME_LEN = 16
) (
  input  logic        sys_clk_50,
  input  logic        sys_rstn,
  tlk_word_if.snk     i_word,
  output logic        o_frame_end,
  output logic [15:0] o_txd,
  output logic        o_tkmsb,
  output logic        o_tklsb
);
  import tlk_pkg::*;

  logic in_frame;
  logic take;      // word belongs to a frame that started with sof

  assign take = i_word.valid && (i_word.sof || in_frame);

  // seen by the controller one cycle ahead of the pins
  assign o_frame_end = take && (i_word.idx == 16'(FRAME_LEN - 1));

  always_ff @(posedge sys_clk_50) begin
    if (!sys_rstn) begin
      in_frame <= 1'b0;
    end else if (o_frame_end) begin
      in_frame <= 1'b0;
    end else if (take && i_word.sof) begin
      in_frame <= 1'b1;
    end
  end

  // transmit pins, comma whenever there is no data
  always_ff @(posedge sys_clk_50) begin
    if (!sys_rstn) begin
      o_txd   <= COMMA_WORD;
      o_tkmsb <= 1'b0;
      o_tklsb <= 1'b1;
    end else if (take) begin
      o_txd   <= i_word.data;
      o_tkmsb <= i_word.kmsb;
      o_tklsb <= i_word.klsb;
    end else begin
      o_txd   <= COMMA_WORD;
      o_tkmsb <= 1'b0;
      o_tklsb <= 1'b1;
    end
  end

endmodule

// ==== tlk_pattern_gen.sv ====
module tlk_pattern_gen #(
  parameter int FRAME_LEN = 16
) (
  input  logic               sys_clk_50,
  input  logic               sys_rstn,
  input  logic               i_run,
  input  tlk_pkg::tlk_mode_e i_mode,
  tlk_word_if.src            o_word
);
  import tlk_pkg::*;

  localparam int SLOT_W = $clog2(FRAME_LEN + 1);

  // slot 0 is the comma slot, 1..FRAME_LEN carry data
  logic [SLOT_W-1:0] slot;
  logic [15:0]       lfsr;  // value for the next data word
  logic [15:0]       idx;
  logic              send;

  assign send = i_run && mode_has_data(i_mode);
  assign idx  = 16'(slot) - 16'd1;

  // data words carry no K characters
  assign o_word.kmsb = 1'b0;
  assign o_word.klsb = 1'b0;

  always_ff @(posedge sys_clk_50) begin
    if (!sys_rstn) begin
      slot         <= '0;
      o_word.valid <= 1'b0;
      o_word.sof   <= 1'b0;
    end else if (slot == '0) begin
      o_word.valid <= 1'b0; // framer fills this with the comma
      o_word.sof   <= 1'b0;
      if (send) begin
        slot <= SLOT_W'(1);
      end
    end else if (slot == SLOT_W'(1) && !send) begin
      // run fell during the comma slot, no new frame
      slot         <= '0;
      o_word.valid <= 1'b0;
      o_word.sof   <= 1'b0;
    end else begin
      o_word.valid <= 1'b1;
      o_word.sof   <= (slot == SLOT_W'(1));
      if (slot == SLOT_W'(FRAME_LEN)) begin
        slot <= '0;
      end else begin
        slot <= slot + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk_50) begin
    if (slot == '0) begin
      lfsr <= LFSR_SEED; // restart every frame
    end else begin
      lfsr <= lfsr_step(lfsr);
    end
    o_word.idx <= idx;
    case (i_mode)
      MODE_COUNT, MODE_LOOP: o_word.data <= idx;
      MODE_LFSR:             o_word.data <= lfsr;
      MODE_ALT:              o_word.data <= idx[0] ? 16'h5555 : 16'hAAAA;
      default:               o_word.data <= '0;
    endcase
  end

endmodule

// ==== tlk_link_ctrl.sv ====
module tlk_link_ctrl #(
  parameter int POWERUP_CYCLES = 64
) (
  input  logic               sys_clk_50,
  input  logic               sys_rstn,
  input  logic               i_start,
  input  tlk_pkg::tlk_mode_e i_mode,
  input  logic               i_stop_req,
  input  logic               i_frame_end,
  output logic               o_run,
  output tlk_pkg::tlk_mode_e o_mode,
  output logic               o_stop_ack,
  output logic               o_enable,
  output logic               o_lckrefn,
  output logic               o_loopen,
  output logic               o_prbsen,
  output logic               o_testen
);
  import tlk_pkg::*;

  localparam int PWR_W = $clog2(POWERUP_CYCLES + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN, // stop requested, finishing the current frame
    ST_ACK
  } state_e;

  state_e           state;
  logic [PWR_W-1:0] pwr_cnt;
  logic             pwr_up;

  // serdes held in reset until the counter saturates
  always_ff @(posedge sys_clk_50) begin
    if (!sys_rstn) begin
      pwr_cnt <= '0;
      pwr_up  <= 1'b0;
    end else if (!pwr_up) begin
      if (pwr_cnt == PWR_W'(POWERUP_CYCLES - 1)) begin
        pwr_up <= 1'b1;
      end else begin
        pwr_cnt <= pwr_cnt + 1'b1;
      end
    end
  end

  assign o_enable  = pwr_up;
  assign o_lckrefn = pwr_up;
  assign o_testen  = 1'b0; // factory test mode never used

  always_ff @(posedge sys_clk_50) begin
    if (!sys_rstn) begin
      state      <= ST_IDLE;
      o_run      <= 1'b0;
      o_mode     <= MODE_IDLE;
      o_stop_ack <= 1'b0;
      o_loopen   <= 1'b0;
      o_prbsen   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_start && pwr_up && !i_stop_req) begin
            state    <= ST_RUN;
            o_run    <= 1'b1;
            o_mode   <= i_mode;
            o_loopen <= (i_mode == MODE_LOOP);
            o_prbsen <= (i_mode == MODE_PRBS);
          end
        end
        ST_RUN: begin
          if (i_stop_req) begin
            if (mode_has_data(o_mode)) begin
              state <= ST_DRAIN;
            end else begin
              // nothing framed, ack right away
              state      <= ST_ACK;
              o_run      <= 1'b0;
              o_stop_ack <= 1'b1;
              o_loopen   <= 1'b0;
              o_prbsen   <= 1'b0;
            end
          end
        end
        ST_DRAIN: begin
          if (!i_stop_req) begin
            state <= ST_RUN; // request withdrawn
          end else if (i_frame_end) begin
            state      <= ST_ACK;
            o_run      <= 1'b0;
            o_stop_ack <= 1'b1;
            o_loopen   <= 1'b0;
            o_prbsen   <= 1'b0;
          end
        end
        ST_ACK: begin
          if (!i_stop_req) begin
            state      <= ST_IDLE;
            o_stop_ack <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== tlk_word_if.sv ====
interface tlk_word_if;

  logic [15:0] data;
  logic        kmsb;
  logic        klsb;
  logic        valid;
  logic        sof;   // first data word after the comma
  logic [15:0] idx;   // word index inside the frame

  modport src (
    output data, kmsb, klsb, valid, sof, idx
  );

  modport snk (
    input data, kmsb, klsb, valid, sof, idx
  );

endinterface

// ==== tlk_pkg.sv ====
package tlk_pkg;

  // test pattern selected by i_mode, 6 and 7 behave as idle
  typedef enum logic [2:0] {
    MODE_IDLE  = 3'd0, // commas only
    MODE_COUNT = 3'd1,
    MODE_LFSR  = 3'd2,
    MODE_ALT   = 3'd3,
    MODE_LOOP  = 3'd4, // counter data, serdes loopback on
    MODE_PRBS  = 3'd5  // serdes internal prbs, pins carry commas
  } tlk_mode_e;

  // K28.5 in the low byte, sent with tklsb high
  localparam logic [15:0] COMMA_WORD = 16'hC5BC;
  localparam logic [15:0] LFSR_SEED  = 16'hACE1;

  // bound of the unrolled lfsr walk in pattern_word
  // frames up to this many words are covered
  localparam int LFSR_MAX_STEPS = 256;

  // modes that put pattern words on the lane
  function automatic logic mode_has_data(tlk_mode_e mode);
    return mode inside {MODE_COUNT, MODE_LFSR, MODE_ALT, MODE_LOOP};
  endfunction

  // fibonacci step, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  function automatic logic [15:0] pattern_word(tlk_mode_e mode, logic [15:0] idx);
    logic [15:0] v;
    v = '0;
    case (mode)
      MODE_COUNT, MODE_LOOP: v = idx;
      MODE_LFSR: begin
        v = LFSR_SEED;
        for (int k = 0; k < LFSR_MAX_STEPS; k++) begin
          if (k < int'(idx)) v = lfsr_step(v);
        end
      end
      MODE_ALT: v = idx[0] ? 16'h5555 : 16'hAAAA;
      default: v = '0;
    endcase
    return v;
  endfunction

endpackage
